// ==== pmp_defs.svh ====
// Shared sizes and CSR numbers for the PMP unit, included by every file that needs them
`ifndef PMP_DEFS_SVH
`define PMP_DEFS_SVH

////////////////////
// Datapath widths
////////////////////

// Register width of the hart, RV64
`define XLEN 64

// Physical address width seen by the memory system
`define PA_BITS 56

// Number of PMP entries, kept a multiple of 8 so config words are full
`define PMP_ENTRIES 16

////////////////////
// CSR numbers
////////////////////

// First pmpcfg CSR
// On RV64 only the even numbers exist, each one holding eight entries
`define PMPCFG0_CSR 12'h3A0

// First pmpaddr CSR, one per entry from here upward
`define PMPADDR0_CSR 12'h3B0

`endif

// ==== pmpPkg.sv ====
// Types shared by the PMP register block, the address decoders and the checker
`include "pmp_defs.svh"

package pmpPkg;

  // Privilege level of the access, encoded as in mstatus.MPP
  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_S = 2'b01,
    PRIV_M = 2'b11
  } privModeT;

  // Address matching mode from the A field of a pmpcfg byte
  typedef enum logic [1:0] {
    ADDR_OFF   = 2'b00,
    ADDR_TOR   = 2'b01,
    ADDR_NA4   = 2'b10,
    ADDR_NAPOT = 2'b11
  } addrModeT;

  // One entry's configuration byte, MSB first as in the spec
  typedef struct packed {
    logic     l;
    logic [1:0] rsvd;
    addrModeT a;
    logic     x;
    logic     w;
    logic     r;
  } pmpCfgT;

  // A pmpcfg CSR word is written and read as raw bits
  // The checker sees the same bits as eight separate entries
  typedef union packed {
    logic [63:0]  raw;
    pmpCfgT [7:0] entry;
  } pmpCfgWordU;

  // One physical access with its level strobes
  typedef struct packed {
    logic [`PA_BITS-1:0] physAddr;
    privModeT            priv;
    logic                fetch;
    logic                load;
    logic                store;
  } accessReqT;

  // Access fault flags toward the trap logic
  typedef struct packed {
    logic instr;
    logic load;
    logic store;
  } accessFaultT;

  // Machine-mode CSR port, a write is a one-cycle strobe
  typedef struct packed {
    logic             wrEn;
    logic [11:0]      csrNum;
    logic [`XLEN-1:0] wrData;
  } csrReqT;

endpackage

// ==== pmpAddrDecoder.sv ====
// Address match for one PMP entry in OFF, TOR, NA4 or NAPOT mode, chained to its neighbours
`timescale 1ns/1ns
`include "pmp_defs.svh"

module pmpAddrDecoder (
  input  logic [`PA_BITS-1:0] physAddr,
  input  pmpPkg::pmpCfgT      cfg,
  input  logic [`XLEN-1:0]    pmpAddr,
  input  logic [`XLEN-1:0]    prevAddr,
  input  logic                aboveIn,
  input  logic                noLowerMatchIn,
  output logic                aboveOut,
  output logic                noLowerMatchOut,
  output logic                match,
  output logic                active,
  output logic                l,
  output logic                x,
  output logic                w,
  output logic                r
);

  localparam int AW = `PA_BITS-2;

  logic [AW-1:0] wordAddr;
  logic [AW-1:0] regAddr;
  logic [AW-1:0] napotCare;
  logic          torMatch;
  logic          na4Match;
  logic          napotMatch;
  logic          winner;

  // pmpaddr holds bits PA_BITS-1:2 of the address, so compare on word addresses
  assign wordAddr = physAddr[`PA_BITS-1:2];
  assign regAddr  = pmpAddr[AW-1:0];

  ////////////////////
  // Per-mode compare
  ////////////////////

  // This entry's bound doubles as the lower bound of the next entry's TOR range
  assign aboveOut = wordAddr >= regAddr;

  // TOR covers prev <= addr < this, the lower half comes in on the chain
  assign torMatch = aboveIn && !aboveOut;

  // NA4 is a single naturally aligned word
  assign na4Match = wordAddr == regAddr;

  // Adding one flips the trailing ones and the zero above them
  // Those bits are don't-care, which gives a region of 2^(ones+3) bytes
  assign napotCare  = ~(regAddr ^ (regAddr + 1'b1));
  assign napotMatch = ((wordAddr ^ regAddr) & napotCare) == '0;

  always_comb begin
    unique case (cfg.a)
      pmpPkg::ADDR_TOR:   match = torMatch;
      pmpPkg::ADDR_NA4:   match = na4Match;
      pmpPkg::ADDR_NAPOT: match = napotMatch;
      default:            match = 1'b0;
    endcase
  end

  assign active = cfg.a != pmpPkg::ADDR_OFF;

  ////////////////////
  // Priority chain
  ////////////////////

  // The lowest-numbered match wins, later entries see the chain broken
  assign winner          = match && noLowerMatchIn;
  assign noLowerMatchOut = noLowerMatchIn && !match;

  // Permissions only leave the winning entry so the checker can OR them
  assign l = winner && cfg.l;
  assign x = winner && cfg.x;
  assign w = winner && cfg.w;
  assign r = winner && cfg.r;

  offNeverMatches: assert final (!(match && !active))
    else $error("PMP entry matched while its mode is OFF");

  // The chained bit has to agree with the bound of the entry below
  aboveChainAgrees: assert final (aboveIn == (wordAddr >= prevAddr[AW-1:0]))
    else $error("PMP TOR chain disagrees with the previous address register");

endmodule

// ==== pmpChecker.sv ====
// Checks one physical access against all PMP entries and raises access faults and bus squash
`timescale 1ns/1ns
`include "pmp_defs.svh"

module pmpChecker (
  input  pmpPkg::accessReqT   req,
  input  pmpPkg::pmpCfgWordU  cfgWords [`PMP_ENTRIES/8],
  input  logic [`XLEN-1:0]    addrRegs [`PMP_ENTRIES],
  output pmpPkg::accessFaultT fault,
  output logic                squashBusAccess
);

  pmpPkg::pmpCfgT          cfgEntry [`PMP_ENTRIES];
  logic [`XLEN-1:0]        prevAddr [`PMP_ENTRIES];
  logic [`PMP_ENTRIES-1:0] aboveOut;
  logic [`PMP_ENTRIES-1:0] noLowerMatch;
  logic [`PMP_ENTRIES-1:0] active;
  logic [`PMP_ENTRIES-1:0] lVec;
  logic [`PMP_ENTRIES-1:0] xVec;
  logic [`PMP_ENTRIES-1:0] wVec;
  logic [`PMP_ENTRIES-1:0] rVec;
  logic                    enforce;

  // Split each config word into its eight entries
  // Entry 0 takes address zero as the bottom of its TOR range
  always_comb begin
    prevAddr[0] = '0;
    for (int i = 0; i < `PMP_ENTRIES; i++) begin
      cfgEntry[i] = cfgWords[i/8].entry[i%8];
      if (i > 0) begin
        prevAddr[i] = addrRegs[i-1];
      end
    end
  end

  ////////////////////
  // Entry decoders
  ////////////////////

  // Both chains start true at entry 0
  for (genvar i = 0; i < `PMP_ENTRIES; i++) begin : gEntry
    pmpAddrDecoder decoder_i (
      .physAddr        (req.physAddr),
      .cfg             (cfgEntry[i]),
      .pmpAddr         (addrRegs[i]),
      .prevAddr        (prevAddr[i]),
      .aboveIn         ((i == 0) ? 1'b1 : aboveOut[(i == 0) ? 0 : i-1]),
      .noLowerMatchIn  ((i == 0) ? 1'b1 : noLowerMatch[(i == 0) ? 0 : i-1]),
      .aboveOut        (aboveOut[i]),
      .noLowerMatchOut (noLowerMatch[i]),
      .match           (),
      .active          (active[i]),
      .l               (lVec[i]),
      .x               (xVec[i]),
      .w               (wVec[i]),
      .r               (rVec[i])
    );
  end

  ////////////////////
  // Enforcement
  ////////////////////

  // M mode is only bound by a locked winning entry
  // S and U are bound as soon as any entry is on, so a miss means no access
  assign enforce = (req.priv == pmpPkg::PRIV_M) ? |lVec : |active;

  assign fault.instr = enforce && req.fetch && !(|xVec);
  assign fault.load  = enforce && req.load  && !(|rVec);
  assign fault.store = enforce && req.store && !(|wVec);

  assign squashBusAccess = fault.instr || fault.load || fault.store;

  // A fault must come from its own strobe, never from a neighbouring access type
  faultNeedsStrobe: assert final (
    !(fault.instr && !req.fetch) &&
    !(fault.load && !req.load) &&
    !(fault.store && !req.store))
    else $error("PMP fault raised without its access strobe");

endmodule

// ==== pmpCsrFile.sv ====
// PMP configuration and address registers with lock rules, written and read through the CSR port
`timescale 1ns/1ns
`include "pmp_defs.svh"

module pmpCsrFile (
  input  logic                clk,
  input  logic                rstN,
  input  pmpPkg::csrReqT      csrReq,
  output logic [`XLEN-1:0]    rdData,
  output logic                csrHit,
  output pmpPkg::pmpCfgWordU  cfgWords [`PMP_ENTRIES/8],
  output logic [`XLEN-1:0]    addrRegs [`PMP_ENTRIES]
);

  localparam int CFG_WORDS = `PMP_ENTRIES/8;
  // Only address bits 2 and up are kept, shifted down by two
  localparam int ADDR_W = `PA_BITS-2;

  pmpPkg::pmpCfgWordU      cfgQ [CFG_WORDS];
  pmpPkg::pmpCfgWordU      cfgNext [CFG_WORDS];
  logic [CFG_WORDS-1:0]    cfgWe;
  logic [ADDR_W-1:0]       addrQ [`PMP_ENTRIES];
  logic [`PMP_ENTRIES-1:0] addrWe;
  pmpPkg::pmpCfgT          cfgEntry [`PMP_ENTRIES];
  logic [`PMP_ENTRIES-1:0] entryLocked;
  logic [`PMP_ENTRIES-1:0] torLocked;
  logic [`PMP_ENTRIES-1:0] addrLocked;
  logic [11:0]             cfgOffset;
  logic [11:0]             addrOffset;
  logic                    isCfg;
  logic                    isAddr;

  ////////////////////
  // CSR decode
  ////////////////////

  // Numbers below the base wrap to large offsets and miss both ranges
  assign cfgOffset  = csrReq.csrNum - `PMPCFG0_CSR;
  assign addrOffset = csrReq.csrNum - `PMPADDR0_CSR;

  // Odd pmpcfg numbers do not exist on RV64
  assign isCfg  = (cfgOffset < 12'(`PMP_ENTRIES/4)) && !cfgOffset[0];
  assign isAddr = addrOffset < 12'(`PMP_ENTRIES);
  assign csrHit = isCfg || isAddr;

  ////////////////////
  // Lock state
  ////////////////////

  always_comb begin
    for (int i = 0; i < `PMP_ENTRIES; i++) begin
      cfgEntry[i]    = cfgQ[i/8].entry[i%8];
      entryLocked[i] = cfgEntry[i].l;
      torLocked[i]   = cfgEntry[i].l && (cfgEntry[i].a == pmpPkg::ADDR_TOR);
    end
  end

  // A locked TOR entry also freezes the lower bound held by the entry below it
  assign addrLocked = entryLocked | {1'b0, torLocked[`PMP_ENTRIES-1:1]};

  ////////////////////
  // Write path
  ////////////////////

  always_comb begin
    for (int k = 0; k < CFG_WORDS; k++) begin
      cfgWe[k]       = csrReq.wrEn && isCfg && (cfgOffset[11:1] == 11'(k));
      cfgNext[k].raw = csrReq.wrData;
      for (int b = 0; b < 8; b++) begin
        // Reserved bits are WARL and read as zero
        cfgNext[k].entry[b].rsvd = 2'b00;
        // Locked bytes keep their value while their neighbours take the new data
        if (cfgQ[k].entry[b].l) begin
          cfgNext[k].entry[b] = cfgQ[k].entry[b];
        end
      end
    end
    for (int i = 0; i < `PMP_ENTRIES; i++) begin
      addrWe[i] = csrReq.wrEn && isAddr && (addrOffset == 12'(i)) && !addrLocked[i];
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int k = 0; k < CFG_WORDS; k++) begin
        cfgQ[k] <= '0;
      end
      for (int i = 0; i < `PMP_ENTRIES; i++) begin
        addrQ[i] <= '0;
      end
    end else begin
      for (int k = 0; k < CFG_WORDS; k++) begin
        if (cfgWe[k]) begin
          cfgQ[k] <= cfgNext[k];
        end
      end
      for (int i = 0; i < `PMP_ENTRIES; i++) begin
        if (addrWe[i]) begin
          addrQ[i] <= csrReq.wrData[ADDR_W-1:0];
        end
      end
    end
  end

  ////////////////////
  // Readback and outputs
  ////////////////////

  always_comb begin
    rdData = '0;
    for (int k = 0; k < CFG_WORDS; k++) begin
      if (isCfg && (cfgOffset[11:1] == 11'(k))) begin
        rdData = cfgQ[k].raw;
      end
    end
    for (int i = 0; i < `PMP_ENTRIES; i++) begin
      // Upper address bits beyond the physical range read as zero
      addrRegs[i] = `XLEN'(addrQ[i]);
      if (isAddr && (addrOffset == 12'(i))) begin
        rdData = addrRegs[i];
      end
    end
  end

  assign cfgWords = cfgQ;

  // Once locked an entry stays as it is until reset, whatever the CSR port does
  for (genvar i = 0; i < `PMP_ENTRIES; i++) begin : gLockCheck
    lockedCfgStable: assert property (@(posedge clk) disable iff (!rstN)
      cfgEntry[i].l |=> $stable(cfgEntry[i]))
      else $error("locked pmpcfg entry %0d changed", i);
  end

endmodule

// ==== pmpUnit.sv ====
// Top of the PMP unit, joining the register block to the access checker
`timescale 1ns/1ns
`include "pmp_defs.svh"

module pmpUnit (
  input  logic                clk,
  input  logic                rstN,
  // Machine-mode CSR port
  input  pmpPkg::csrReqT      csrReq,
  // Physical access to check, strobes are levels
  input  pmpPkg::accessReqT   access,
  output logic [`XLEN-1:0]    csrRdData,
  output logic                csrHit,
  output pmpPkg::accessFaultT fault,
  output logic                squashBusAccess
);

  // Register state as seen by the checker, updated one edge after a CSR write
  pmpPkg::pmpCfgWordU cfgWords [`PMP_ENTRIES/8];
  logic [`XLEN-1:0]   addrRegs [`PMP_ENTRIES];

  ////////////////////
  // Register block
  ////////////////////

  pmpCsrFile csrFile_i (
    .clk      (clk),
    .rstN     (rstN),
    .csrReq   (csrReq),
    .rdData   (csrRdData),
    .csrHit   (csrHit),
    .cfgWords (cfgWords),
    .addrRegs (addrRegs)
  );

  ////////////////////
  // Access check
  ////////////////////

  // Purely combinational, faults follow the request in the same cycle
  pmpChecker checker_i (
    .req             (access),
    .cfgWords        (cfgWords),
    .addrRegs        (addrRegs),
    .fault           (fault),
    .squashBusAccess (squashBusAccess)
  );

endmodule

// ==== pmpUnitTb.sv ====
// Self-checking testbench for the PMP unit, applies a table of CSR and access steps to the DUT
`timescale 1ns/1ns
`include "pmp_defs.svh"

module pmpUnitTb;

  localparam int RESET_CYCLES = 8;
  localparam logic [1:0] KIND_WRITE  = 2'd0;
  localparam logic [1:0] KIND_READ   = 2'd1;
  localparam logic [1:0] KIND_ACCESS = 2'd2;
  localparam logic [11:0] CFG0  = `PMPCFG0_CSR;
  localparam logic [11:0] ADDR0 = `PMPADDR0_CSR;

  // One table row, strobes and fault bits both ordered as fetch/instr, load, store
  typedef struct packed {
    logic [1:0]            kind;
    logic [11:0]           csrNum;
    logic [`XLEN-1:0]      data;
    logic                  expHit;
    logic [`PA_BITS-1:0]   addr;
    pmpPkg::privModeT      priv;
    logic [2:0]            strobes;
    logic [2:0]            expFault;
  } stepT;

  logic                clk;
  logic                rstN;
  pmpPkg::csrReqT      csrReq;
  pmpPkg::accessReqT   access;
  logic [`XLEN-1:0]    csrRdData;
  logic                csrHit;
  pmpPkg::accessFaultT fault;
  logic                squashBusAccess;

  stepT        steps [$];
  logic [31:0] lfsr;
  int          checkCount;
  int          errorCount;
  int          cycleCount;
  int          cycleLimit;

  pmpUnit dut_i (
    .clk             (clk),
    .rstN            (rstN),
    .csrReq          (csrReq),
    .access          (access),
    .csrRdData       (csrRdData),
    .csrHit          (csrHit),
    .fault           (fault),
    .squashBusAccess (squashBusAccess)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////
  // Helpers
  ////////////////////

  // Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit handed out
  function automatic logic [63:0] randBits(input int n);
    logic [63:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[62:0], fb};
    end
    return v;
  endfunction

  // U-mode faults for the NA4/NAPOT layout, all three strobes set
  // The 4 KiB NAPOT region at 0x10000 is execute only, the NA4 word at 0x20008 is write only
  function automatic logic [2:0] regionFault(input logic [`PA_BITS-1:0] addr);
    if (addr[`PA_BITS-1:12] == 'h10) return 3'b011;
    if (addr[`PA_BITS-1:2] == ('h20008 >> 2)) return 3'b110;
    return 3'b111;
  endfunction

  task automatic checkValue(input string name, input logic [63:0] exp, input logic [63:0] got);
    checkCount++;
    if (exp !== got) begin
      errorCount++;
      $display("mismatch %s exp %h got %h", name, exp, got);
    end
  endtask

  task automatic addWrite(input logic [11:0] num, input logic [63:0] data);
    steps.push_back('{KIND_WRITE, num, data, 1'b0, '0, pmpPkg::PRIV_M, 3'b000, 3'b000});
  endtask

  task automatic addRead(input logic [11:0] num, input logic [63:0] data, input logic hit);
    steps.push_back('{KIND_READ, num, data, hit, '0, pmpPkg::PRIV_M, 3'b000, 3'b000});
  endtask

  task automatic addAccess(input logic [`PA_BITS-1:0] addr, input pmpPkg::privModeT priv,
                           input logic [2:0] strobes, input logic [2:0] expFault);
    steps.push_back('{KIND_ACCESS, 12'h000, '0, 1'b0, addr, priv, strobes, expFault});
  endtask

  task automatic buildTable();
    logic [`PA_BITS-1:0] a;
    // Nothing is active after reset, in any mode
    addAccess('h1800, pmpPkg::PRIV_U, 3'b111, 3'b000);
    addAccess('h1800, pmpPkg::PRIV_S, 3'b111, 3'b000);
    addAccess('h1800, pmpPkg::PRIV_M, 3'b111, 3'b000);
    addRead(CFG0, '0, 1'b1);
    addRead(CFG0 + 12'd2, '0, 1'b1);
    // Odd pmpcfg numbers are absent on RV64
    addRead(CFG0 + 12'd1, '0, 1'b0);
    for (int i = 0; i < `PMP_ENTRIES; i++) addRead(ADDR0 + 12'(i), '0, 1'b1);

    ////////////////////
    // TOR, read only between 0x1000 and 0x2000
    addWrite(ADDR0, 'h400);
    addWrite(ADDR0 + 12'd1, 'h800);
    addWrite(CFG0, 64'h0900);
    addRead(CFG0, 64'h0900, 1'b1);
    addAccess('h1800, pmpPkg::PRIV_U, 3'b010, 3'b000);
    addAccess('h1800, pmpPkg::PRIV_U, 3'b001, 3'b001);
    addAccess('h1800, pmpPkg::PRIV_U, 3'b100, 3'b100);
    addAccess('h1000, pmpPkg::PRIV_U, 3'b010, 3'b000);
    addAccess('h1ffc, pmpPkg::PRIV_U, 3'b010, 3'b000);
    addAccess('h2000, pmpPkg::PRIV_U, 3'b010, 3'b010);
    addAccess('h0ffc, pmpPkg::PRIV_U, 3'b010, 3'b010);
    addAccess('h0500, pmpPkg::PRIV_S, 3'b111, 3'b111);
    addAccess('h1800, pmpPkg::PRIV_M, 3'b111, 3'b000);
    addAccess('h3000, pmpPkg::PRIV_M, 3'b111, 3'b000);

    ////////////////////
    // NAPOT 4 KiB execute only in entry 2, NA4 write only in entry 3, TOR switched off
    addWrite(ADDR0 + 12'd2, 'h41ff);
    addWrite(ADDR0 + 12'd3, 'h8002);
    addWrite(CFG0, 64'h121c_0000);
    addAccess('h0fffc, pmpPkg::PRIV_U, 3'b111, 3'b111);
    addAccess('h11000, pmpPkg::PRIV_U, 3'b111, 3'b111);
    addAccess('h20004, pmpPkg::PRIV_U, 3'b111, 3'b111);
    addAccess('h2000c, pmpPkg::PRIV_U, 3'b111, 3'b111);
    for (int i = 0; i < 6; i++) begin
      a = 'h10000 | randBits(12);
      addAccess(a, pmpPkg::PRIV_U, 3'b111, regionFault(a));
      a = 'h20008 | randBits(2);
      addAccess(a, pmpPkg::PRIV_U, 3'b111, regionFault(a));
      a = randBits(20);
      addAccess(a, pmpPkg::PRIV_U, 3'b111, regionFault(a));
    end

    ////////////////////
    // Entry 4 read only over 0x40800 to 0x40fff inside entry 5, RWX over 0x40000 to 0x43fff
    addWrite(ADDR0 + 12'd4, 'h102ff);
    addWrite(ADDR0 + 12'd5, 'h107ff);
    addWrite(CFG0, 64'h1f19_121c_0000);
    addAccess('h40900, pmpPkg::PRIV_U, 3'b111, 3'b101);
    addAccess('h40800, pmpPkg::PRIV_U, 3'b111, 3'b101);
    addAccess('h40ffc, pmpPkg::PRIV_U, 3'b111, 3'b101);
    addAccess('h407fc, pmpPkg::PRIV_U, 3'b111, 3'b000);
    addAccess('h41000, pmpPkg::PRIV_U, 3'b111, 3'b000);
    addAccess('h43ffc, pmpPkg::PRIV_U, 3'b111, 3'b000);
    addAccess('h44000, pmpPkg::PRIV_U, 3'b111, 3'b111);

    ////////////////////
    // Entry 8 locked TOR read only over 0x80000 to 0x8ffff, bounds in entries 7 and 8
    addWrite(ADDR0 + 12'd7, 'h20000);
    addWrite(ADDR0 + 12'd8, 'h24000);
    addWrite(CFG0 + 12'd2, 64'h89);
    addAccess('h88000, pmpPkg::PRIV_M, 3'b111, 3'b101);
    addAccess('h88000, pmpPkg::PRIV_M, 3'b010, 3'b000);
    addAccess('h88000, pmpPkg::PRIV_U, 3'b111, 3'b101);
    // Unlocked entries still leave M mode alone
    addAccess('h40900, pmpPkg::PRIV_M, 3'b111, 3'b000);
    addAccess('h70000, pmpPkg::PRIV_M, 3'b111, 3'b000);
    // Locked byte stays, its neighbour becomes NAPOT RWX
    addWrite(CFG0 + 12'd2, 64'h1f1f);
    addRead(CFG0 + 12'd2, 64'h1f89, 1'b1);
    addWrite(ADDR0 + 12'd8, 'h12345);
    addRead(ADDR0 + 12'd8, 'h24000, 1'b1);
    addWrite(ADDR0 + 12'd7, 'h3333);
    addRead(ADDR0 + 12'd7, 'h20000, 1'b1);
    // All ones makes entry 9 cover everything, upper bits read back as zero
    addWrite(ADDR0 + 12'd9, '1);
    addRead(ADDR0 + 12'd9, 64'h003f_ffff_ffff_ffff, 1'b1);
    addAccess('h70000, pmpPkg::PRIV_U, 3'b111, 3'b000);
    addAccess('h88000, pmpPkg::PRIV_U, 3'b111, 3'b101);
    addAccess('h88000, pmpPkg::PRIV_M, 3'b111, 3'b101);
  endtask

  // Inputs change on the falling edge, outputs are compared at the next rising edge
  task automatic applyStep(input stepT s);
    logic isAccess;
    isAccess = (s.kind == KIND_ACCESS);
    @(negedge clk);
    csrReq.wrEn     = (s.kind == KIND_WRITE);
    csrReq.csrNum   = s.csrNum;
    csrReq.wrData   = s.data;
    access.physAddr = s.addr;
    access.priv     = s.priv;
    access.fetch    = isAccess && s.strobes[2];
    access.load     = isAccess && s.strobes[1];
    access.store    = isAccess && s.strobes[0];
    @(posedge clk);
    if (s.kind == KIND_READ) begin
      checkValue("csrRdData", s.data, csrRdData);
      checkValue("csrHit", s.expHit, csrHit);
    end
    checkValue("fault", s.expFault, fault);
    checkValue("squashBusAccess", |s.expFault, squashBusAccess);
  endtask

  ////////////////////
  // Watchdog
  ////////////////////

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount > cycleLimit) begin
      $display("Run stopped after %0d cycles without reaching the end of the table", cycleCount);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    lfsr       = 32'h69e7_2e3e;
    checkCount = 0;
    errorCount = 0;
    cycleCount = 0;
    rstN       = 1'b0;
    csrReq     = '0;
    access     = '0;
    buildTable();
    // Each step takes one cycle, so four per step leaves ample margin
    cycleLimit = steps.size() * 4 + RESET_CYCLES;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
    foreach (steps[i]) applyStep(steps[i]);
    $display("steps %0d checks %0d errors %0d", steps.size(), checkCount, errorCount);
    if (errorCount == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+.
pmpPkg.sv
pmpAddrDecoder.sv
pmpChecker.sv
pmpCsrFile.sv
pmpUnit.sv
pmpUnitTb.sv
